// File: cla_mult.f
+incdir+include
design/mult_pkg.sv
design/cla_adder.sv
design/pp_front.sv
design/tree_stage_reg.sv
design/pp_back.sv
design/cla_mult_top.sv
tests/cla_mult_tb.sv

// File: design/cla_adder.sv
`timescale 1ns/1ps

// width must be a multiple of 4
module cla_adder #(
    parameter int width = 64
) (
    input  logic [width-1:0] x,
    input  logic [width-1:0] y,
    output logic [width-1:0] sum
);
    import mult_pkg::*;

    localparam int num_groups = width / CLA_GROUP_W;

    logic [width-1:0]      g;
    logic [width-1:0]      p;
    logic [num_groups-1:0] grp_c;

    assign g = x & y;
    assign p = x ^ y;

    // no carry in
    assign grp_c[0] = 1'b0;

    for (genvar i = 0; i < num_groups; i++) begin : gen_group
        logic [CLA_GROUP_W-1:0] gg;
        logic [CLA_GROUP_W-1:0] pg;
        logic [CLA_GROUP_W-1:0] c;

        assign gg = g[i*CLA_GROUP_W +: CLA_GROUP_W];
        assign pg = p[i*CLA_GROUP_W +: CLA_GROUP_W];

        // lookahead carries from the group carry in
        assign c[0] = grp_c[i];
        assign c[1] = gg[0] | (pg[0] & c[0]);
        assign c[2] = gg[1]
                    | (gg[0] & pg[1])
                    | (c[0] & pg[0] & pg[1]);
        assign c[3] = gg[2]
                    | (gg[1] & pg[2])
                    | (gg[0] & pg[1] & pg[2])
                    | (c[0] & pg[0] & pg[1] & pg[2]);

        assign sum[i*CLA_GROUP_W +: CLA_GROUP_W] = pg ^ c;

        // group carry out feeds the next group and the top one is dropped
        if (i < num_groups - 1) begin : gen_cout
            assign grp_c[i+1] = gg[3]
                              | (gg[2] & pg[3])
                              | (gg[1] & pg[2] & pg[3])
                              | (gg[0] & pg[1] & pg[2] & pg[3])
                              | (c[0] & pg[0] & pg[1] & pg[2] & pg[3]);
        end
    end

endmodule

// File: design/cla_mult_top.sv
`timescale 1ns/1ps

// unsigned 32x32 multiply, three register stages
module cla_mult_top (
    input  logic                           clk,
    input  logic                           rst_n,
    input  mult_pkg::pipe_en_t             en,
    input  mult_pkg::operand_t             a,
    input  mult_pkg::operand_t             b,
    output logic [mult_pkg::OPERAND_W-1:0] hi,
    output logic [mult_pkg::OPERAND_W-1:0] lo
);
    import mult_pkg::*;

    mid_sums_t mid_sums;
    mid_sums_t mid_sums_q;

    pp_front i_front (
        .clk      (clk),
        .rst_n    (rst_n),
        .in_en    (en.in_en),
        .a        (a),
        .b        (b),
        .mid_sums (mid_sums)
    );

    tree_stage_reg i_stage (
        .clk        (clk),
        .rst_n      (rst_n),
        .stage_en   (en.stage_en),
        .mid_sums   (mid_sums),
        .mid_sums_q (mid_sums_q)
    );

    pp_back i_back (
        .clk        (clk),
        .rst_n      (rst_n),
        .out_en     (en.out_en),
        .mid_sums_q (mid_sums_q),
        .hi         (hi),
        .lo         (lo)
    );

endmodule

// File: design/mult_pkg.sv
package mult_pkg;

    ////////////////////////////////////////
    // widths
    ////////////////////////////////////////

    localparam int OPERAND_W = 32;
    localparam int PRODUCT_W = 2 * OPERAND_W;

    // carry lookahead group size
    localparam int CLA_GROUP_W = 4;

    ////////////////////////////////////////
    // reduction tree
    ////////////////////////////////////////

    // one partial product per bit of b
    localparam int NUM_PP = OPERAND_W;

    // sums left after levels 0 and 1
    localparam int NUM_MID_SUMS = NUM_PP / 4;

    typedef logic [OPERAND_W-1:0] operand_t;
    typedef logic [PRODUCT_W-1:0] product_t;

    // level-1 sums, sum_0 first
    typedef struct packed {
        product_t sum_0;
        product_t sum_1;
        product_t sum_2;
        product_t sum_3;
        product_t sum_4;
        product_t sum_5;
        product_t sum_6;
        product_t sum_7;
    } mid_sums_t;

    // one load strobe per register stage
    typedef struct packed {
        logic in_en;
        logic stage_en;
        logic out_en;
    } pipe_en_t;

endpackage

// File: design/pp_back.sv
`timescale 1ns/1ps

module pp_back (
    input  logic                         clk,
    input  logic                         rst_n,
    input  logic                         out_en,
    input  mult_pkg::mid_sums_t          mid_sums_q,
    output logic [mult_pkg::OPERAND_W-1:0] hi,
    output logic [mult_pkg::OPERAND_W-1:0] lo
);
    import mult_pkg::*;

    product_t [NUM_MID_SUMS-1:0]   s;
    product_t [NUM_MID_SUMS/2-1:0] lvl2;
    product_t [NUM_MID_SUMS/4-1:0] lvl3;
    product_t                      product;

    assign s[0] = mid_sums_q.sum_0;
    assign s[1] = mid_sums_q.sum_1;
    assign s[2] = mid_sums_q.sum_2;
    assign s[3] = mid_sums_q.sum_3;
    assign s[4] = mid_sums_q.sum_4;
    assign s[5] = mid_sums_q.sum_5;
    assign s[6] = mid_sums_q.sum_6;
    assign s[7] = mid_sums_q.sum_7;

    ////////////////////////////////////////
    // adder levels 2 to 4
    ////////////////////////////////////////

    for (genvar i = 0; i < NUM_MID_SUMS/2; i++) begin : gen_lvl2
        cla_adder #(
            .width(PRODUCT_W)
        ) i_add (
            .x   (s[2*i]),
            .y   (s[2*i+1]),
            .sum (lvl2[i])
        );
    end

    for (genvar i = 0; i < NUM_MID_SUMS/4; i++) begin : gen_lvl3
        cla_adder #(
            .width(PRODUCT_W)
        ) i_add (
            .x   (lvl2[2*i]),
            .y   (lvl2[2*i+1]),
            .sum (lvl3[i])
        );
    end

    // final sum is the full product
    cla_adder #(
        .width(PRODUCT_W)
    ) i_add_lvl4 (
        .x   (lvl3[0]),
        .y   (lvl3[1]),
        .sum (product)
    );

    ////////////////////////////////////////
    // output registers
    ////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            hi <= '0;
            lo <= '0;
        end else if (out_en) begin
            hi <= product[PRODUCT_W-1:OPERAND_W];
            lo <= product[OPERAND_W-1:0];
        end
    end

endmodule

// File: design/pp_front.sv
`timescale 1ns/1ps

module pp_front (
    input  logic                clk,
    input  logic                rst_n,
    input  logic                in_en,
    input  mult_pkg::operand_t  a,
    input  mult_pkg::operand_t  b,
    output mult_pkg::mid_sums_t mid_sums
);
    import mult_pkg::*;

    operand_t a_q;
    operand_t b_q;

    product_t [NUM_PP-1:0]       pp;
    product_t [NUM_PP/2-1:0]     lvl0;
    product_t [NUM_MID_SUMS-1:0] lvl1;

    ////////////////////////////////////////
    // operand register
    ////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            a_q <= '0;
            b_q <= '0;
        end else if (in_en) begin
            a_q <= a;
            b_q <= b;
        end
    end

    ////////////////////////////////////////
    // partial products
    ////////////////////////////////////////

    // a gated by bit i of b, padded and shifted into place
    for (genvar i = 0; i < NUM_PP; i++) begin : gen_pp
        assign pp[i] = product_t'(a_q & {OPERAND_W{b_q[i]}}) << i;
    end

    ////////////////////////////////////////
    // adder levels 0 and 1
    ////////////////////////////////////////

    for (genvar i = 0; i < NUM_PP/2; i++) begin : gen_lvl0
        cla_adder #(
            .width(PRODUCT_W)
        ) i_add (
            .x   (pp[2*i]),
            .y   (pp[2*i+1]),
            .sum (lvl0[i])
        );
    end

    for (genvar i = 0; i < NUM_MID_SUMS; i++) begin : gen_lvl1
        cla_adder #(
            .width(PRODUCT_W)
        ) i_add (
            .x   (lvl0[2*i]),
            .y   (lvl0[2*i+1]),
            .sum (lvl1[i])
        );
    end

    assign mid_sums.sum_0 = lvl1[0];
    assign mid_sums.sum_1 = lvl1[1];
    assign mid_sums.sum_2 = lvl1[2];
    assign mid_sums.sum_3 = lvl1[3];
    assign mid_sums.sum_4 = lvl1[4];
    assign mid_sums.sum_5 = lvl1[5];
    assign mid_sums.sum_6 = lvl1[6];
    assign mid_sums.sum_7 = lvl1[7];

endmodule

// File: design/tree_stage_reg.sv
`timescale 1ns/1ps

// pipeline cut between the two halves of the adder tree
module tree_stage_reg (
    input  logic                clk,
    input  logic                rst_n,
    input  logic                stage_en,
    input  mult_pkg::mid_sums_t mid_sums,
    output mult_pkg::mid_sums_t mid_sums_q
);

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            mid_sums_q <= '0;
        end else if (stage_en) begin
            mid_sums_q <= mid_sums;
        end
    end

endmodule

// File: run_sim.sh
#!/usr/bin/env bash
# build and run the cla_mult testbench with Verilator
set -e

cd "$(dirname "$0")"

build_dir=obj_dir
log_file=sim.log

verilator --binary --timing --assert \
    --top-module cla_mult_tb \
    -f cla_mult.f \
    --Mdir "$build_dir" \
    -o cla_mult_sim

"./$build_dir/cla_mult_sim" | tee "$log_file"

if grep -q "^Done: no errors$" "$log_file"; then
    echo "simulation passed"
    exit 0
else
    echo "simulation failed, see $log_file"
    exit 1
fi

// File: include/cla_mult_vectors.svh
`ifndef CLA_MULT_VECTORS_SVH
`define CLA_MULT_VECTORS_SVH

// one directed case, operands and full product
typedef struct packed {
    mult_pkg::operand_t a;
    mult_pkg::operand_t b;
    mult_pkg::product_t prod;
} mult_vec_t;

localparam int num_vectors = 12;

localparam mult_vec_t mult_vectors [num_vectors] = '{
    // zeros
    '{32'h0000_0000, 32'h0000_0000, 64'h0000_0000_0000_0000},
    '{32'hffff_ffff, 32'h0000_0000, 64'h0000_0000_0000_0000},
    // identity
    '{32'h0000_0001, 32'h0000_0001, 64'h0000_0000_0000_0001},
    '{32'hdead_beef, 32'h0000_0001, 64'h0000_0000_dead_beef},
    // largest operands
    '{32'hffff_ffff, 32'hffff_ffff, 64'hffff_fffe_0000_0001},
    // powers of two
    '{32'h8000_0000, 32'h8000_0000, 64'h4000_0000_0000_0000},
    '{32'h0001_0000, 32'h0001_0000, 64'h0000_0001_0000_0000},
    // alternating bits
    '{32'haaaa_aaaa, 32'h5555_5555, 64'h38e3_8e38_71c7_1c72},
    // mixed
    '{32'hffff_0000, 32'h0000_ffff, 64'h0000_fffe_0001_0000},
    '{32'h8000_0001, 32'h8000_0001, 64'h4000_0001_0000_0001},
    '{32'h0000_0003, 32'h5555_5555, 64'h0000_0000_ffff_ffff},
    '{32'h1234_5678, 32'h0000_0010, 64'h0000_0001_2345_6780}
};

`endif

// File: tests/cla_mult_tb.sv
`timescale 1ns/1ps

module cla_mult_tb;
    import mult_pkg::*;

    `include "cla_mult_vectors.svh"

    localparam int clk_period    = 4;
    localparam int drive_delay   = 1;
    localparam int reset_cycles  = 16;
    localparam int clear_timeout = 10;
    localparam int num_random    = 200;
    localparam int hold_cycles   = 5;

    logic                 clk;
    logic                 rst_n;
    pipe_en_t             en;
    operand_t             a;
    operand_t             b;
    logic [OPERAND_W-1:0] hi;
    logic [OPERAND_W-1:0] lo;

    // expected contents of operand, stage and output registers
    product_t exp_in;
    product_t exp_stage;
    product_t exp_out;
    string    tag_in;
    string    tag_stage;
    string    tag_out;

    int unsigned seed;
    int          num_checks;
    int          num_errors;

    cla_mult_top i_dut (
        .clk   (clk),
        .rst_n (rst_n),
        .en    (en),
        .a     (a),
        .b     (b),
        .hi    (hi),
        .lo    (lo)
    );

    initial begin
        clk = 1'b0;
        forever begin
            #(clk_period / 2) clk = ~clk;
        end
    end

    ////////////////////////////////////////
    // helpers
    ////////////////////////////////////////

    // full unsigned product
    function automatic product_t ref_product(input operand_t x, input operand_t y);
        product_t wide_x;
        product_t wide_y;
        wide_x = product_t'(x);
        wide_y = product_t'(y);
        return wide_x * wide_y;
    endfunction

    function automatic pipe_en_t make_en(input logic load_in, input logic load_stage,
                                         input logic load_out);
        pipe_en_t e;
        e.in_en    = load_in;
        e.stage_en = load_stage;
        e.out_en   = load_out;
        return e;
    endfunction

    task automatic check_value(input string name, input product_t expected,
                               input product_t actual);
        num_checks++;
        assert (actual === expected) else begin
            num_errors++;
            $display("CHECK FAILED %s: expected %h, actual %h", name, expected, actual);
        end
    endtask

    // drive one clock, advance the expected registers and check hi/lo
    task automatic tick(input string test, input string tag, input pipe_en_t e,
                        input operand_t x, input operand_t y, input product_t expected);
        en = e;
        a  = x;
        b  = y;
        @(posedge clk);
        if (e.out_en) begin
            exp_out = exp_stage;
            tag_out = tag_stage;
        end
        if (e.stage_en) begin
            exp_stage = exp_in;
            tag_stage = tag_in;
        end
        if (e.in_en) begin
            exp_in = expected;
            tag_in = tag;
        end
        #(drive_delay);
        check_value($sformatf("%s %s", test, tag_out), exp_out, {hi, lo});
    endtask

    task automatic wait_outputs_clear();
        int cycles;
        cycles = 0;
        while ({hi, lo} !== '0 && cycles < clear_timeout) begin
            @(posedge clk);
            #(drive_delay);
            cycles++;
        end
        if ({hi, lo} !== '0) begin
            num_errors++;
            $display("timeout: hi and lo did not read zero within %0d cycles after reset",
                     clear_timeout);
        end
    endtask

    ////////////////////////////////////////
    // main sequence
    ////////////////////////////////////////

    initial begin
        int       i;
        operand_t ra;
        operand_t rb;
        operand_t first_a;
        operand_t first_b;
        product_t held;
        product_t first;

        seed       = $urandom(32'hcbb0_5cef);
        num_checks = 0;
        num_errors = 0;
        rst_n      = 1'b0;
        en         = '0;
        a          = '0;
        b          = '0;
        exp_in     = '0;
        exp_stage  = '0;
        exp_out    = '0;
        tag_in     = "reset";
        tag_stage  = "reset";
        tag_out    = "reset";

        for (i = 0; i < reset_cycles; i++) begin
            @(posedge clk);
        end
        #(drive_delay);
        rst_n = 1'b1;

        // registers stay cleared while all strobes are low
        wait_outputs_clear();
        check_value("reset", '0, {hi, lo});
        for (i = 0; i < 3; i++) begin
            ra = $urandom;
            rb = $urandom;
            tick("reset", "idle", make_en(1'b0, 1'b0, 1'b0), ra, rb, ref_product(ra, rb));
        end

        // directed rows back to back
        for (i = 0; i < num_vectors; i++) begin
            tick("table", $sformatf("row %0d", i), make_en(1'b1, 1'b1, 1'b1),
                 mult_vectors[i].a, mult_vectors[i].b, mult_vectors[i].prod);
        end
        for (i = 0; i < 3; i++) begin
            tick("table", "flush", make_en(1'b1, 1'b1, 1'b1), '0, '0, '0);
        end

        for (i = 0; i < num_random; i++) begin
            ra = $urandom;
            rb = $urandom;
            tick("random", $sformatf("pair %0d", i), make_en(1'b1, 1'b1, 1'b1),
                 ra, rb, ref_product(ra, rb));
        end

        ////////////////////////////////////////
        // stalls
        ////////////////////////////////////////

        // output frozen while new pairs keep entering
        held = exp_out;
        for (i = 0; i < hold_cycles; i++) begin
            ra = $urandom;
            rb = $urandom;
            tick("out hold", $sformatf("pair %0d", i), make_en(1'b1, 1'b1, 1'b0),
                 ra, rb, ref_product(ra, rb));
        end
        check_value("out hold kept", held, {hi, lo});
        for (i = 0; i < 4; i++) begin
            ra = $urandom;
            rb = $urandom;
            tick("out resume", $sformatf("pair %0d", i), make_en(1'b1, 1'b1, 1'b1),
                 ra, rb, ref_product(ra, rb));
        end

        first_a = $urandom;
        first_b = $urandom;
        first   = ref_product(first_a, first_b);
        tick("stage hold", "first", make_en(1'b1, 1'b0, 1'b0), first_a, first_b, first);
        ra = $urandom;
        rb = $urandom;
        tick("stage hold", "second", make_en(1'b1, 1'b1, 1'b0), ra, rb, ref_product(ra, rb));
        for (i = 0; i < 3; i++) begin
            ra = $urandom;
            rb = $urandom;
            tick("stage hold", $sformatf("extra %0d", i), make_en(1'b1, 1'b0, 1'b0),
                 ra, rb, ref_product(ra, rb));
        end
        // stage register should still carry the first pair
        tick("stage hold", "drain", make_en(1'b0, 1'b0, 1'b1), '0, '0, '0);
        check_value("stage hold result", first, {hi, lo});

        $display("checks: %0d, errors: %0d", num_checks, num_errors);
        if (num_errors == 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    end

endmodule
